// ==== exec_pkg.sv ====
`default_nettype none

package exec_pkg;

  // basic data and address word
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // register file depth, x0 included
  localparam int NUM_REGS = 32;

  // all-ones word decodes as halt
  localparam word_t HALT_INSN = 32'hffff_ffff;

  // major opcodes of the supported rv32i subset
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  // funct3 of loads
  // stores share the same codes
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } load_type_e;

  // funct3 of conditional branches
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_type_e;

  typedef enum logic [1:0] {W_LOAD, W_PC4, W_IMM_U, W_ALU} w_sel_e;
  typedef enum logic [1:0] {A_RS1, A_PC, A_ZERO} a_sel_e;
  typedef enum logic [1:0] {B_RS2, B_IMM_I, B_IMM_U} b_sel_e;

  // registered word from fetch
  typedef struct packed {
    word_t pc;
    word_t pc4;
    word_t instr;
    logic  prediction;
  } fetch_ex_t;

  // decoded control with sign-extended immediates
  typedef struct packed {
    reg_addr_t    rs1;
    reg_addr_t    rs2;
    reg_addr_t    rd;
    alu_op_e      alu_op;
    a_sel_e       a_sel;
    b_sel_e       b_sel;
    w_sel_e       w_sel;
    load_type_e   load_type;
    branch_type_e branch_type;
    word_t        imm_i;
    word_t        imm_s;
    word_t        imm_sb;
    word_t        imm_uj;
    word_t        imm_u;
    logic         wen;
    logic         dren;
    logic         dwen;
    logic         branch;
    logic         jump;
    logic         j_sel;
    logic         halt;
    logic         illegal;
  } ctrl_t;

  // data bus request in little-endian lanes
  typedef struct packed {
    word_t      addr;
    word_t      wdata;
    logic [3:0] byte_en;
    logic       ren;
    logic       wen;
  } dbus_req_t;

  typedef struct packed {
    word_t rdata;
    logic  busy;
  } dbus_rsp_t;

endpackage

`default_nettype wire

// ==== control_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_decode
  import exec_pkg::*;
(
  input  word_t instr,
  output ctrl_t ctrl
);

  // funct3 plus the alternate bit to an alu operation
  function automatic alu_op_e alu_from_funct(input logic [2:0] funct3, input logic alt);
    alu_op_e op;
    case (funct3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  logic [2:0] funct3;

  assign funct3 = instr[14:12];

  always_comb begin
    ctrl = '0;
    // register fields sit at fixed positions
    ctrl.rs1 = instr[19:15];
    ctrl.rs2 = instr[24:20];
    ctrl.rd  = instr[11:7];
    ctrl.alu_op = ALU_ADD;
    ctrl.a_sel  = A_RS1;
    ctrl.b_sel  = B_RS2;
    ctrl.w_sel  = W_ALU;
    // width and compare come straight from funct3
    ctrl.load_type   = load_type_e'(funct3);
    ctrl.branch_type = branch_type_e'(funct3);
    // every immediate format sign-extended
    ctrl.imm_i  = {{20{instr[31]}}, instr[31:20]};
    ctrl.imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    ctrl.imm_sb = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    ctrl.imm_uj = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    ctrl.imm_u  = {instr[31:12], 12'b0};

    if (instr == HALT_INSN) begin
      // halt writes nothing and touches no memory
      ctrl.halt = 1'b1;
    end else begin
      case (opcode_e'(instr[6:0]))
        OP_LUI: begin
          ctrl.a_sel = A_ZERO;
          ctrl.b_sel = B_IMM_U;
          ctrl.w_sel = W_IMM_U;
          ctrl.wen   = 1'b1;
        end
        OP_AUIPC: begin
          ctrl.a_sel = A_PC;
          ctrl.b_sel = B_IMM_U;
          ctrl.wen   = 1'b1;
        end
        OP_JAL: begin
          ctrl.jump  = 1'b1;
          ctrl.j_sel = 1'b1;
          ctrl.w_sel = W_PC4;
          ctrl.wen   = 1'b1;
        end
        OP_JALR: begin
          ctrl.jump  = 1'b1;
          ctrl.w_sel = W_PC4;
          ctrl.wen   = 1'b1;
        end
        OP_BRANCH: begin
          ctrl.branch = 1'b1;
        end
        OP_LOAD: begin
          ctrl.b_sel = B_IMM_I;
          ctrl.w_sel = W_LOAD;
          ctrl.dren  = 1'b1;
          ctrl.wen   = 1'b1;
        end
        OP_STORE: begin
          // offset comes from the S format inside the alu unit
          ctrl.b_sel = B_IMM_I;
          ctrl.dwen  = 1'b1;
        end
        OP_IMM: begin
          // only srai uses bit 30
          // addi has no subtract form
          ctrl.alu_op = alu_from_funct(funct3, (funct3 == 3'b101) & instr[30]);
          ctrl.b_sel  = B_IMM_I;
          ctrl.wen    = 1'b1;
        end
        OP_REG: begin
          ctrl.alu_op = alu_from_funct(funct3, instr[30]);
          ctrl.wen    = 1'b1;
        end
        default: begin
          ctrl.illegal = 1'b1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file
  import exec_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  reg_addr_t rd,
  input  word_t     w_data,
  input  logic      wen,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  // x0 has no storage
  word_t regs [1:NUM_REGS-1];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (rd != '0)) begin
      regs[rd] <= w_data;
    end
  end

  // combinational reads with x0 as zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== alu_branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_branch_unit
  import exec_pkg::*;
(
  input  fetch_ex_t fetch_ex,
  input  ctrl_t     ctrl,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  output word_t     alu_out,
  output word_t     brj_addr,
  output logic      mispredict
);

  word_t      port_a;
  word_t      port_b;
  logic [4:0] shamt;
  logic       cmp;
  logic       taken;
  word_t      branch_addr;
  word_t      jal_addr;
  word_t      jalr_addr;

  // operand a
  always_comb begin
    case (ctrl.a_sel)
      A_RS1:   port_a = rs1_data;
      A_PC:    port_a = fetch_ex.pc;
      default: port_a = '0;
    endcase
  end

  // operand b
  // stores take the S offset in the immediate slot
  always_comb begin
    case (ctrl.b_sel)
      B_RS2:   port_b = rs2_data;
      B_IMM_I: port_b = ctrl.dwen ? ctrl.imm_s : ctrl.imm_i;
      B_IMM_U: port_b = ctrl.imm_u;
      default: port_b = '0;
    endcase
  end

  // shift amount is the low five bits of b
  assign shamt = port_b[4:0];

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:  alu_out = port_a + port_b;
      ALU_SUB:  alu_out = port_a - port_b;
      ALU_SLL:  alu_out = port_a << shamt;
      ALU_SLT:  alu_out = {31'b0, $signed(port_a) < $signed(port_b)};
      ALU_SLTU: alu_out = {31'b0, port_a < port_b};
      ALU_XOR:  alu_out = port_a ^ port_b;
      ALU_SRL:  alu_out = port_a >> shamt;
      ALU_SRA:  alu_out = $signed(port_a) >>> shamt;
      ALU_OR:   alu_out = port_a | port_b;
      ALU_AND:  alu_out = port_a & port_b;
      default:  alu_out = '0;
    endcase
  end

  // branch compare on the raw register values
  always_comb begin
    case (ctrl.branch_type)
      BEQ:     cmp = (rs1_data == rs2_data);
      BNE:     cmp = (rs1_data != rs2_data);
      BLT:     cmp = ($signed(rs1_data) < $signed(rs2_data));
      BGE:     cmp = ($signed(rs1_data) >= $signed(rs2_data));
      BLTU:    cmp = (rs1_data < rs2_data);
      BGEU:    cmp = (rs1_data >= rs2_data);
      default: cmp = 1'b0;
    endcase
  end

  // targets
  assign branch_addr = fetch_ex.pc + ctrl.imm_sb;
  assign jal_addr    = fetch_ex.pc + ctrl.imm_uj;
  assign jalr_addr   = (rs1_data + ctrl.imm_i) & ~32'h1;

  // jumps always count as taken
  assign taken = ctrl.jump | (ctrl.branch & cmp);

  assign brj_addr = ctrl.jump ? (ctrl.j_sel ? jal_addr : jalr_addr) :
                    taken     ? branch_addr : fetch_ex.pc4;

  assign mispredict = fetch_ex.prediction ^ taken;

endmodule

`default_nettype wire

// ==== load_store_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_store_unit
  import exec_pkg::*;
(
  input  ctrl_t     ctrl,
  input  word_t     addr,
  input  word_t     rs2_data,
  input  dbus_rsp_t dbus_rsp,
  output dbus_req_t dbus_req,
  output word_t     load_data,
  output logic      mal,
  output logic      mal_l,
  output logic      mal_s
);

  logic [1:0] byte_offset;
  logic [3:0] byte_en;
  logic       mis_addr;
  word_t      store_data;
  word_t      lane;

  assign byte_offset = addr[1:0];

  // byte enables from width and offset
  // lane 0 is the low byte
  always_comb begin
    case (ctrl.load_type)
      LB, LBU: byte_en = 4'b0001 << byte_offset;
      LH, LHU: byte_en = byte_offset[0] ? 4'b0000 :
                         byte_offset[1] ? 4'b1100 : 4'b0011;
      LW:      byte_en = 4'b1111;
      default: byte_en = 4'b0000;
    endcase
  end

  // word off a 4-byte boundary or halfword at an odd address
  always_comb begin
    case (ctrl.load_type)
      LH, LHU: mis_addr = byte_offset[0];
      LW:      mis_addr = (byte_offset != 2'b00);
      default: mis_addr = 1'b0;
    endcase
  end

  assign mal_l = ctrl.dren & mis_addr;
  assign mal_s = ctrl.dwen & mis_addr;
  assign mal   = mal_l | mal_s;

  // replicate store data across lanes
  // memory picks lanes via byte_en
  always_comb begin
    case (ctrl.load_type)
      LB:      store_data = {4{rs2_data[7:0]}};
      LH:      store_data = {2{rs2_data[15:0]}};
      default: store_data = rs2_data;
    endcase
  end

  // bus request
  // no access on a misaligned address
  assign dbus_req.addr    = addr;
  assign dbus_req.wdata   = store_data;
  assign dbus_req.byte_en = byte_en;
  assign dbus_req.ren     = ctrl.dren & ~mis_addr;
  assign dbus_req.wen     = ctrl.dwen & ~mis_addr;

  // move the addressed lane down to bit 0
  assign lane = dbus_rsp.rdata >> {byte_offset, 3'b000};

  always_comb begin
    case (ctrl.load_type)
      LB:      load_data = {{24{lane[7]}}, lane[7:0]};
      LBU:     load_data = {24'b0, lane[7:0]};
      LH:      load_data = {{16{lane[15]}}, lane[15:0]};
      LHU:     load_data = {16'b0, lane[15:0]};
      LW:      load_data = dbus_rsp.rdata;
      default: load_data = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== writeback_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeback_select
  import exec_pkg::*;
(
  input  ctrl_t     ctrl,
  input  fetch_ex_t fetch_ex,
  input  word_t     alu_out,
  input  word_t     load_data,
  input  logic      stall,
  input  logic      busy,
  input  logic      mal,
  output word_t     w_data,
  output logic      wen
);

  // result source
  always_comb begin
    case (ctrl.w_sel)
      W_LOAD:  w_data = load_data;
      W_PC4:   w_data = fetch_ex.pc4;
      W_IMM_U: w_data = ctrl.imm_u;
      W_ALU:   w_data = alu_out;
      default: w_data = alu_out;
    endcase
  end

  // write only on the cycle the instruction retires
  // a misaligned load leaves rd untouched
  assign wen = ctrl.wen & ~stall & ~busy & ~(ctrl.dren & mal);

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage
  import exec_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  fetch_ex_t fetch_ex,
  input  logic      stall,
  input  dbus_rsp_t dbus_rsp,
  output dbus_req_t dbus_req,
  output word_t     brj_addr,
  output logic      mispredict,
  output logic      mal_l,
  output logic      mal_s,
  output logic      illegal,
  output logic      halt
);

  ctrl_t ctrl;
  word_t rs1_data;
  word_t rs2_data;
  word_t alu_out;
  word_t load_data;
  word_t w_data;
  logic  mal;
  logic  rf_wen;

  control_decode control_decode_inst (
    .instr (fetch_ex.instr),
    .ctrl  (ctrl)
  );

  reg_file reg_file_inst (
    .CLK      (CLK),
    .nRST     (nRST),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .rd       (ctrl.rd),
    .w_data   (w_data),
    .wen      (rf_wen),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  alu_branch_unit alu_branch_unit_inst (
    .fetch_ex   (fetch_ex),
    .ctrl       (ctrl),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .alu_out    (alu_out),
    .brj_addr   (brj_addr),
    .mispredict (mispredict)
  );

  // alu result doubles as the data address
  load_store_unit load_store_unit_inst (
    .ctrl      (ctrl),
    .addr      (alu_out),
    .rs2_data  (rs2_data),
    .dbus_rsp  (dbus_rsp),
    .dbus_req  (dbus_req),
    .load_data (load_data),
    .mal       (mal),
    .mal_l     (mal_l),
    .mal_s     (mal_s)
  );

  writeback_select writeback_select_inst (
    .ctrl      (ctrl),
    .fetch_ex  (fetch_ex),
    .alu_out   (alu_out),
    .load_data (load_data),
    .stall     (stall),
    .busy      (dbus_rsp.busy),
    .mal       (mal),
    .w_data    (w_data),
    .wen       (rf_wen)
  );

  assign illegal = ctrl.illegal;

  // sticky halt cleared only by reset
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      halt <= 1'b0;
    end else if (ctrl.halt && !stall) begin
      halt <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== execute_stage_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage_properties
  import exec_pkg::*;
(
  input logic      CLK,
  input logic      nRST,
  input dbus_req_t dbus_req,
  input dbus_rsp_t dbus_rsp,
  input logic      mal_l,
  input logic      mal_s,
  input logic      halt
);

  // number of assertion failures so far
  int fail_count = 0;

  // an access reads or writes but never both
  ren_wen_exclusive: assert property (@(posedge CLK) disable iff (!nRST)
    !(dbus_req.ren && dbus_req.wen))
  else begin
    fail_count++;
    $error("ren and wen high in the same cycle");
  end

  // misaligned address blocks the access
  misaligned_no_access: assert property (@(posedge CLK) disable iff (!nRST)
    (mal_l || mal_s) |-> (!dbus_req.ren && !dbus_req.wen))
  else begin
    fail_count++;
    $error("bus access issued on a misaligned address");
  end

  // request frozen while memory is busy
  req_steady_when_busy: assert property (@(posedge CLK) disable iff (!nRST)
    dbus_rsp.busy |=> $stable(dbus_req))
  else begin
    fail_count++;
    $error("dbus_req changed while busy was high");
  end

  // halt only clears through reset
  halt_sticky: assert property (@(posedge CLK) disable iff (!nRST)
    halt |=> halt)
  else begin
    fail_count++;
    $error("halt fell without reset");
  end

endmodule

`default_nettype wire

// ==== execute_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage_tb
  import exec_pkg::*;
;

  // one table row of stimulus and expected response
  typedef struct packed {
    word_t      instr;
    word_t      pc;
    logic       pred;
    logic       stall;
    // wdata, addr with byte_en, brj_addr with mispredict
    logic [2:0] chk;
    word_t      addr;
    word_t      wdata;
    logic [3:0] be;
    logic       ren;
    logic       wen;
    word_t      brj;
    logic       misp;
    // mal_l, mal_s, illegal, halt
    logic [3:0] flags;
  } row_t;

  logic      CLK;
  logic      nRST;
  logic      stall;
  logic      busy;
  fetch_ex_t fetch_ex;
  dbus_rsp_t dbus_rsp;
  dbus_req_t dbus_req;
  word_t     brj_addr;
  logic      mispredict;
  logic      mal_l;
  logic      mal_s;
  logic      illegal;
  logic      halt;

  // memory model
  // word index from addr[7:2]
  word_t mem [64];

  row_t  rows [$];
  string names [$];
  row_t  cur;
  string cur_name;
  logic  halt_due;
  int    seed = 4;
  int    errors = 0;
  int    passed = 0;
  int    failed = 0;

  execute_stage execute_stage_inst (
    .CLK        (CLK),
    .nRST       (nRST),
    .fetch_ex   (fetch_ex),
    .stall      (stall),
    .dbus_rsp   (dbus_rsp),
    .dbus_req   (dbus_req),
    .brj_addr   (brj_addr),
    .mispredict (mispredict),
    .mal_l      (mal_l),
    .mal_s      (mal_s),
    .illegal    (illegal),
    .halt       (halt)
  );

  bind execute_stage execute_stage_properties execute_stage_properties_inst (
    .CLK      (CLK),
    .nRST     (nRST),
    .dbus_req (dbus_req),
    .dbus_rsp (dbus_rsp),
    .mal_l    (mal_l),
    .mal_s    (mal_s),
    .halt     (halt)
  );

  // rv32i encoders in ISA manual field order
  function automatic word_t r_type(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_REG};
  endfunction

  function automatic word_t i_type(int op, int f3, int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
  endfunction

  function automatic word_t s_type(int f3, int rs1, int rs2, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], OP_STORE};
  endfunction

  function automatic word_t b_type(int f3, int rs1, int rs2, int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic word_t u_type(int rd, int imm);
    return {imm[31:12], rd[4:0], OP_LUI};
  endfunction

  function automatic word_t j_type(int rd, int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
  endfunction

  // every byte depends on the word index
  function automatic word_t fill_word(int idx);
    return {idx[7:0] ^ 8'ha5, idx[7:0], ~idx[7:0], idx[7:0] + 8'h3c};
  endfunction

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // writes land per byte lane once busy is low
  always @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < $size(mem); i++) begin
        mem[i] <= fill_word(i);
      end
    end else if (dbus_req.wen && !busy) begin
      for (int b = 0; b < 4; b++) begin
        if (dbus_req.byte_en[b]) begin
          mem[dbus_req.addr[7:2]][8*b +: 8] <= dbus_req.wdata[8*b +: 8];
        end
      end
    end
  end

  // read data follows the address while busy paces the access
  assign dbus_rsp = '{rdata: mem[dbus_req.addr[7:2]], busy: busy};

  task automatic begin_row(input string name, input word_t instr);
    cur = '0;
    cur.instr = instr;
    cur.pc = 32'h100;
    cur.flags[0] = halt_due;
    cur_name = name;
  endtask

  task automatic commit_row();
    rows.push_back(cur);
    names.push_back(cur_name);
  endtask

  task automatic plain_row(input string name, input word_t instr);
    begin_row(name, instr);
    commit_row();
  endtask

  task automatic store_row(input string name, input word_t instr, input word_t addr,
                           input word_t wdata, input logic [3:0] be);
    begin_row(name, instr);
    cur.wen = 1'b1;
    cur.chk = 3'b011;
    cur.addr = addr;
    cur.wdata = wdata;
    cur.be = be;
    commit_row();
  endtask

  task automatic load_row(input string name, input word_t instr, input word_t addr,
                          input logic [3:0] be);
    begin_row(name, instr);
    cur.ren = 1'b1;
    cur.chk = 3'b010;
    cur.addr = addr;
    cur.be = be;
    commit_row();
  endtask

  // branch rows all sit at pc 0x200
  task automatic branch_row(input string name, input word_t instr, input logic pred,
                            input word_t brj, input logic misp);
    begin_row(name, instr);
    cur.pc = 32'h200;
    cur.pred = pred;
    cur.chk = 3'b100;
    cur.brj = brj;
    cur.misp = misp;
    commit_row();
  endtask

  task automatic build_table();
    word_t      alu_exp [10];
    int         ld_f3 [6];
    int         ld_off [6];
    logic [3:0] ld_be [6];
    word_t      ld_exp [6];
    alu_exp = '{32'h5, 32'hffff_fffd, 32'h1234_5000, 32'h1234_5005, 32'h8,
                32'h50, 32'hffff_fffe, 32'hf, 32'h1, 32'h0};
    ld_f3  = '{0, 0, 4, 1, 5, 2};
    ld_off = '{0, 1, 1, 2, 0, 0};
    ld_be  = '{4'b0001, 4'b0010, 4'b0010, 4'b1100, 4'b0011, 4'b1111};
    // word 0xc0 holds 9530_cf6c after reset
    ld_exp = '{32'h6c, 32'hffff_ffcf, 32'hcf, 32'hffff_9530, 32'hcf6c, 32'h9530_cf6c};
    halt_due = 1'b0;
    // alu results into x1..x10 and then stored one by one
    plain_row("addi x1,x0,5", i_type(OP_IMM, 0, 1, 0, 5));
    plain_row("addi x2,x0,-3", i_type(OP_IMM, 0, 2, 0, -3));
    plain_row("lui x3,0x12345", u_type(3, 32'h1234_5000));
    plain_row("add x4,x1,x3", r_type(0, 3, 1, 0, 4));
    plain_row("sub x5,x1,x2", r_type(32, 2, 1, 0, 5));
    plain_row("slli x6,x1,4", i_type(OP_IMM, 1, 6, 1, 4));
    plain_row("srai x7,x2,1", i_type(OP_IMM, 5, 7, 2, 'h401));
    plain_row("srli x8,x2,28", i_type(OP_IMM, 5, 8, 2, 28));
    plain_row("slt x9,x2,x1", r_type(0, 1, 2, 2, 9));
    plain_row("sltu x10,x2,x1", r_type(0, 1, 2, 3, 10));
    for (int r = 1; r <= 10; r++) begin
      store_row($sformatf("sw x%0d", r), s_type(2, 0, r, 'h40), 32'h40, alu_exp[r-1], 4'hf);
    end
    // byte and halfword stores of x4 at every offset
    for (int k = 0; k < 4; k++) begin
      store_row($sformatf("sb x4 at 0x%0h", 'h80 + k), s_type(0, 0, 4, 'h80 + k),
                32'h80 + k, 32'h0505_0505, 4'b0001 << k);
    end
    store_row("sh x4 at 0x80", s_type(1, 0, 4, 'h80), 32'h80, 32'h5005_5005, 4'b0011);
    store_row("sh x4 at 0x82", s_type(1, 0, 4, 'h82), 32'h82, 32'h5005_5005, 4'b1100);
    // loads into x11..x16 each read back by a store
    for (int k = 0; k < 6; k++) begin
      load_row($sformatf("load funct3 %0d at 0x%0h", ld_f3[k], 'hc0 + ld_off[k]),
               i_type(OP_LOAD, ld_f3[k], 11 + k, 0, 'hc0 + ld_off[k]),
               32'hc0 + ld_off[k], ld_be[k]);
      store_row($sformatf("sw x%0d", 11 + k), s_type(2, 0, 11 + k, 'h44), 32'h44,
                ld_exp[k], 4'hf);
    end
    // x1 = 5, x2 = -3
    branch_row("beq taken pred 0", b_type(0, 1, 1, 16), 1'b0, 32'h210, 1'b1);
    branch_row("beq not taken pred 1", b_type(0, 1, 2, 16), 1'b1, 32'h204, 1'b1);
    branch_row("bne taken back pred 1", b_type(1, 1, 2, -8), 1'b1, 32'h1f8, 1'b0);
    branch_row("bne not taken pred 0", b_type(1, 1, 1, 16), 1'b0, 32'h204, 1'b0);
    branch_row("blt taken pred 0", b_type(4, 2, 1, 32), 1'b0, 32'h220, 1'b1);
    branch_row("blt not taken pred 1", b_type(4, 1, 2, 32), 1'b1, 32'h204, 1'b1);
    branch_row("bltu not taken pred 0", b_type(6, 2, 1, 32), 1'b0, 32'h204, 1'b0);
    branch_row("bltu taken pred 1", b_type(6, 1, 2, 32), 1'b1, 32'h220, 1'b0);
    branch_row("jal x17 pred 0", j_type(17, 'h100), 1'b0, 32'h300, 1'b1);
    branch_row("jal x17 pred 1", j_type(17, 'h100), 1'b1, 32'h300, 1'b0);
    // 5 + 0x10 with the low bit cleared
    branch_row("jalr x18 pred 1", i_type(OP_JALR, 0, 18, 1, 'h10), 1'b1, 32'h14, 1'b0);
    branch_row("jalr x18 pred 0", i_type(OP_JALR, 0, 18, 1, 'h10), 1'b0, 32'h14, 1'b1);
    store_row("sw x17 link", s_type(2, 0, 17, 'h48), 32'h48, 32'h204, 4'hf);
    store_row("sw x18 link", s_type(2, 0, 18, 'h48), 32'h48, 32'h204, 4'hf);
    // misaligned accesses and a stalled write
    begin_row("lw x11 misaligned", i_type(OP_LOAD, 2, 11, 0, 'hc2));
    cur.flags[3] = 1'b1;
    commit_row();
    begin_row("sh x4 misaligned", s_type(1, 0, 4, 'h81));
    cur.flags[2] = 1'b1;
    commit_row();
    store_row("sw x11 kept", s_type(2, 0, 11, 'h4c), 32'h4c, 32'h6c, 4'hf);
    begin_row("addi x19 under stall", i_type(OP_IMM, 0, 19, 0, 'h55));
    cur.stall = 1'b1;
    commit_row();
    store_row("sw x19 not written", s_type(2, 0, 19, 'h4c), 32'h4c, 32'h0, 4'hf);
    // opcode zero is not in the subset
    begin_row("unknown opcode", 32'h0);
    cur.flags[1] = 1'b1;
    commit_row();
    plain_row("halt", HALT_INSN);
    halt_due = 1'b1;
    plain_row("addi x20 after halt", i_type(OP_IMM, 0, 20, 0, 1));
    store_row("sw x20 after halt", s_type(2, 0, 20, 'h50), 32'h50, 32'h1, 4'hf);
  endtask

  // apply on a rising edge and check at the falling edge once busy is low
  task automatic run_row(input int idx);
    row_t r;
    int   waits;
    int   bad;
    r = rows[idx];
    bad = 0;
    waits = (r.ren || r.wen) ? ($unsigned($random(seed)) % 3) : 0;
    fetch_ex <= '{pc: r.pc, pc4: r.pc + 32'd4, instr: r.instr, prediction: r.pred};
    stall <= r.stall;
    busy <= (waits != 0);
    while (waits > 0) begin
      @(posedge CLK);
      waits--;
      busy <= (waits != 0);
    end
    @(negedge CLK);
    if (dbus_req.ren !== r.ren || dbus_req.wen !== r.wen) begin
      $display("[ERROR] %0t %s: ren/wen %b/%b, expected %b/%b", $time, names[idx],
               dbus_req.ren, dbus_req.wen, r.ren, r.wen);
      bad++;
    end
    if (r.chk[0] && dbus_req.wdata !== r.wdata) begin
      $display("[ERROR] %0t %s: wdata %h, expected %h", $time, names[idx],
               dbus_req.wdata, r.wdata);
      bad++;
    end
    if (r.chk[1] && (dbus_req.addr !== r.addr || dbus_req.byte_en !== r.be)) begin
      $display("[ERROR] %0t %s: addr %h byte_en %b, expected %h %b", $time, names[idx],
               dbus_req.addr, dbus_req.byte_en, r.addr, r.be);
      bad++;
    end
    if (r.chk[2] && (brj_addr !== r.brj || mispredict !== r.misp)) begin
      $display("[ERROR] %0t %s: brj_addr %h mispredict %b, expected %h %b", $time,
               names[idx], brj_addr, mispredict, r.brj, r.misp);
      bad++;
    end
    if ({mal_l, mal_s, illegal, halt} !== r.flags) begin
      $display("[ERROR] %0t %s: mal_l/mal_s/illegal/halt %b, expected %b", $time,
               names[idx], {mal_l, mal_s, illegal, halt}, r.flags);
      bad++;
    end
    errors += bad;
    if (bad == 0) begin
      passed++;
    end else begin
      failed++;
    end
    $display("%s %s", (bad == 0) ? "ok" : "FAIL", names[idx]);
    // the instruction retires on this edge
    @(posedge CLK);
  endtask

  initial begin
    nRST = 1'b0;
    stall = 1'b0;
    busy = 1'b0;
    fetch_ex = '0;
    build_table();
    fork
      begin
        // at most three cycles per row plus one spare
        repeat (rows.size() * 4 + 8) @(posedge CLK);
        $display("timeout: the table did not finish within %0d cycles", rows.size() * 4 + 8);
        $display("ERRORS FOUND");
        $finish;
      end
    join_none
    repeat (8) @(posedge CLK);
    nRST <= 1'b1;
    foreach (rows[i]) begin
      run_row(i);
    end
    @(negedge CLK);
    errors += execute_stage_inst.execute_stage_properties_inst.fail_count;
    $display("tests %0d, passed %0d, failed %0d, errors %0d, assertion failures %0d",
             rows.size(), passed, failed, errors,
             execute_stage_inst.execute_stage_properties_inst.fail_count);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
exec_pkg.sv
control_decode.sv
reg_file.sv
alu_branch_unit.sv
load_store_unit.sv
writeback_select.sv
execute_stage.sv
execute_stage_properties.sv
execute_stage_tb.sv

// ==== Bender.yml ====
package:
  name: execute_stage

sources:
  - exec_pkg.sv
  - control_decode.sv
  - reg_file.sv
  - alu_branch_unit.sv
  - load_store_unit.sv
  - writeback_select.sv
  - execute_stage.sv
  - target: test
    files:
      - execute_stage_properties.sv
      - execute_stage_tb.sv
